// File: hdl/mem_pkg.sv
package mem_pkg;

    localparam int WORD_W = 32;
    localparam int BYTE_LANES = WORD_W / 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // access size, matches the core's ACCESS_SZ encoding
    typedef logic [1:0] acc_sz_t;

    localparam acc_sz_t ACCESS_SZ_BYTE = 2'b00;
    localparam acc_sz_t ACCESS_SZ_HALF = 2'b01;
    localparam acc_sz_t ACCESS_SZ_WORD = 2'b10;

    // memory opcodes, anything else is no access
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t OP_LD_B  = 4'h1;
    localparam mem_op_t OP_LD_H  = 4'h2;
    localparam mem_op_t OP_LD_W  = 4'h3;
    localparam mem_op_t OP_LD_BU = 4'h4;
    localparam mem_op_t OP_LD_HU = 4'h5;
    localparam mem_op_t OP_ST_B  = 4'h8;
    localparam mem_op_t OP_ST_H  = 4'h9;
    localparam mem_op_t OP_ST_W  = 4'ha;

    // data memory depth in words
    localparam int DMEM_WORDS = 1024;
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // decode to fake cache
    typedef struct packed {
        logic    re;
        logic    we;
        addr_t   addr;
        word_t   wdata;
        acc_sz_t access_sz;
        logic    sign_ext;
        logic    ale;
    } mem_req_t;

    // fake cache to sram
    typedef struct packed {
        logic     en;
        byte_en_t we;
        addr_t    addr;
        word_t    wdata;
    } sram_req_t;

    // load context carried alongside the sram read
    typedef struct packed {
        logic       valid;
        logic       ale;
        logic [1:0] lane;
        acc_sz_t    access_sz;
        logic       sign_ext;
    } load_tag_t;

endpackage

// File: hdl/mem_op_decode.sv
module mem_op_decode import mem_pkg::*; (
    input  logic        op_valid,
    input  mem_op_t     op,
    input  word_t       base,
    input  logic [11:0] offset,
    input  word_t       store_data,
    output mem_req_t    req,
    output load_tag_t   tag
);

    logic    is_load;
    logic    is_store;
    logic    sign_ext;
    acc_sz_t access_sz;
    addr_t   addr;
    logic    misaligned;
    logic    fault;

    // opcode classification
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        sign_ext  = 1'b0;
        access_sz = ACCESS_SZ_WORD;
        case (op)
            OP_LD_B: begin
                is_load   = 1'b1;
                sign_ext  = 1'b1;
                access_sz = ACCESS_SZ_BYTE;
            end
            OP_LD_H: begin
                is_load   = 1'b1;
                sign_ext  = 1'b1;
                access_sz = ACCESS_SZ_HALF;
            end
            OP_LD_W: begin
                is_load   = 1'b1;
                access_sz = ACCESS_SZ_WORD;
            end
            OP_LD_BU: begin
                is_load   = 1'b1;
                access_sz = ACCESS_SZ_BYTE;
            end
            OP_LD_HU: begin
                is_load   = 1'b1;
                access_sz = ACCESS_SZ_HALF;
            end
            OP_ST_B: begin
                is_store  = 1'b1;
                access_sz = ACCESS_SZ_BYTE;
            end
            OP_ST_H: begin
                is_store  = 1'b1;
                access_sz = ACCESS_SZ_HALF;
            end
            OP_ST_W: begin
                is_store  = 1'b1;
                access_sz = ACCESS_SZ_WORD;
            end
            default: is_load = 1'b0;
        endcase
    end

    // effective address, si12 offset
    assign addr = base + {{20{offset[11]}}, offset};

    always_comb begin
        case (access_sz)
            ACCESS_SZ_HALF: misaligned = addr[0];
            ACCESS_SZ_WORD: misaligned = |addr[1:0];
            default:        misaligned = 1'b0;
        endcase
    end

    assign fault = op_valid & (is_load | is_store) & misaligned;

    // a faulting op never reaches the sram
    always_comb begin
        req.re        = op_valid & is_load & ~misaligned;
        req.we        = op_valid & is_store & ~misaligned;
        req.addr      = addr;
        req.wdata     = store_data;
        req.access_sz = access_sz;
        req.sign_ext  = sign_ext;
        req.ale       = fault;
    end

    // loads and faults both need a response slot
    always_comb begin
        tag.valid     = req.re | req.ale;
        tag.ale       = req.ale;
        tag.lane      = req.addr[1:0];
        tag.access_sz = req.access_sz;
        tag.sign_ext  = req.sign_ext;
    end

endmodule

// File: hdl/fakecache.sv
module fakecache import mem_pkg::*; (
    input  mem_req_t  req,
    input  word_t     sram_rdata,
    input  logic      rst_n,
    output sram_req_t sram,
    output word_t     cache_rdata,
    output logic      cache_hit
);

    byte_en_t lane_mask;
    word_t    lane_data;

    // write mask and lane replicated store data
    always_comb begin
        case (req.access_sz)
            ACCESS_SZ_WORD: begin
                lane_mask = 4'b1111;
                lane_data = req.wdata;
            end
            ACCESS_SZ_HALF: begin
                lane_mask = byte_en_t'(4'b0011 << req.addr[1:0]);
                lane_data = {2{req.wdata[15:0]}};
            end
            ACCESS_SZ_BYTE: begin
                lane_mask = byte_en_t'(4'b0001 << req.addr[1:0]);
                lane_data = {4{req.wdata[7:0]}};
            end
            default: begin
                lane_mask = '0;
                lane_data = '0;
            end
        endcase
    end

    always_comb begin
        sram.en    = req.re | req.we;
        sram.we    = req.we ? lane_mask : '0;
        sram.addr  = req.addr;
        sram.wdata = lane_data;
    end

    // no tags, every access hits once out of reset
    assign cache_rdata = sram_rdata;
    assign cache_hit   = rst_n;

endmodule

// File: hdl/data_sram.sv
module data_sram import mem_pkg::*; (
    input  logic      clk,
    input  sram_req_t sram,
    output word_t     rdata
);

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;

    // word index, upper address bits ignored
    assign idx = sram.addr[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (sram.en) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (sram.we[i]) begin
                    mem[idx][i*8 +: 8] <= sram.wdata[i*8 +: 8];
                end
            end
            // registered read, old data on a write cycle
            rdata <= mem[idx];
        end
    end

endmodule

// File: hdl/load_align.sv
module load_align import mem_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  load_tag_t tag,
    input  word_t     cache_rdata,
    input  logic      cache_hit,
    output logic      load_valid,
    output word_t     load_data,
    output logic      ale
);

    load_tag_t   tag_q;
    word_t       lane_word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // follows the sram access by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q <= tag;
        end
    end

    // move the addressed lane down to bit 0
    assign lane_word = cache_rdata >> {tag_q.lane, 3'b000};
    assign sel_byte  = lane_word[7:0];
    assign sel_half  = lane_word[15:0];

    always_comb begin
        case (tag_q.access_sz)
            ACCESS_SZ_BYTE: begin
                load_data = {{24{tag_q.sign_ext & sel_byte[7]}}, sel_byte};
            end
            ACCESS_SZ_HALF: begin
                load_data = {{16{tag_q.sign_ext & sel_half[15]}}, sel_half};
            end
            default: begin
                load_data = cache_rdata;
            end
        endcase
    end

    // result pulses
    assign load_valid = tag_q.valid & ~tag_q.ale & cache_hit;
    assign ale        = tag_q.valid & tag_q.ale;

endmodule

// File: hdl/mem_subsys.sv
module mem_subsys import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        op_valid,
    input  mem_op_t     op,
    input  word_t       base,
    input  logic [11:0] offset,
    input  word_t       store_data,
    output logic        load_valid,
    output word_t       load_data,
    output logic        ale
);

    mem_req_t  req;
    load_tag_t tag;
    sram_req_t sram_req;
    word_t     sram_rdata;
    word_t     cache_rdata;
    logic      cache_hit;

    mem_op_decode u_decode (
        .op_valid   (op_valid),
        .op         (op),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .req        (req),
        .tag        (tag)
    );

    fakecache u_cache (
        .req         (req),
        .sram_rdata  (sram_rdata),
        .rst_n       (rst_n),
        .sram        (sram_req),
        .cache_rdata (cache_rdata),
        .cache_hit   (cache_hit)
    );

    data_sram u_sram (
        .clk   (clk),
        .sram  (sram_req),
        .rdata (sram_rdata)
    );

    // tag lands here on the same edge as the sram access
    load_align u_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .tag         (tag),
        .cache_rdata (cache_rdata),
        .cache_hit   (cache_hit),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .ale         (ale)
    );

endmodule

// File: dv/mem_subsys_asserts.sv
module mem_subsys_asserts import mem_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input mem_req_t  req,
    input load_tag_t tag,
    input sram_req_t sram_req,
    input logic      load_valid,
    input logic      ale
);

    // failures seen so far
    int unsigned fail_count = 0;

    // a faulting op answers with ale alone
    fault_response: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tag.valid && tag.ale) |=> (ale && !load_valid)
    ) else begin
        $error("fault did not give ale alone one cycle later");
        fail_count++;
    end

    // stores must touch at least one lane
    store_mask_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (sram_req.en && !req.re) |-> (sram_req.we != '0)
    ) else begin
        $error("sram write enabled with an empty byte mask");
        fail_count++;
    end

    // aligned load returns exactly one cycle later, without ale
    load_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tag.valid && !tag.ale) |=> (load_valid && !ale)
    ) else begin
        $error("aligned load did not return alone after one cycle");
        fail_count++;
    end

    // checked mid cycle, the result register clears on the first reset edge
    quiet_in_reset: assert property (
        @(negedge clk)
        !rst_n |-> (!load_valid && !ale)
    ) else begin
        $error("result outputs active during reset");
        fail_count++;
    end

endmodule

// File: dv/mem_subsys_tb.sv
module mem_subsys_tb import mem_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 2000;
    localparam int TOTAL_OPS  = NUM_RANDOM + 120;
    localparam addr_t WIN_BASE = 32'h0000_0200;
    localparam int WIN_WORDS  = 16;
    localparam int WIN_BYTES  = WIN_WORDS * 4;

    // expected response for one issued operation
    typedef struct packed {
        logic        load_valid;
        logic        ale;
        word_t       data;
        logic [31:0] due;
    } exp_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        op_valid;
    mem_op_t     op;
    word_t       base;
    logic [11:0] offset;
    word_t       store_data;
    logic        load_valid;
    word_t       load_data;
    logic        ale;

    integer      seed;
    int unsigned cyc = 0;
    word_t       model_mem [DMEM_WORDS];
    exp_t        exp_q [$];
    mem_op_t     op_tbl [8] = '{OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU,
                                OP_LD_HU, OP_ST_B, OP_ST_H, OP_ST_W};

    mem_subsys i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_valid   (op_valid),
        .op         (op),
        .base       (base),
        .offset     (offset),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .ale        (ale)
    );

    bind mem_subsys mem_subsys_asserts u_asserts (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .tag        (tag),
        .sram_req   (sram_req),
        .load_valid (load_valid),
        .ale        (ale)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int op_bytes(mem_op_t o);
        case (o)
            OP_LD_B, OP_LD_BU, OP_ST_B: return 1;
            OP_LD_H, OP_LD_HU, OP_ST_H: return 2;
            OP_LD_W, OP_ST_W:           return 4;
            default:                    return 0;
        endcase
    endfunction

    // expected response, stores also update the model memory
    function automatic exp_t model_op(mem_op_t o, word_t b, logic [11:0] off, word_t d);
        exp_t  e;
        addr_t a;
        int    nb;
        int    idx;
        int    lane;
        int    i;
        logic  is_ld;
        logic  sgn;
        word_t w;
        e     = '0;
        a     = b + 32'($signed(off));
        nb    = op_bytes(o);
        idx   = int'(a[DMEM_AW+1:2]);
        lane  = int'(a[1:0]);
        is_ld = o inside {OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU};
        sgn   = o inside {OP_LD_B, OP_LD_H};
        if (nb == 0) begin
            return e;
        end
        if ((a % nb) != 0) begin
            e.ale = 1'b1;
            return e;
        end
        if (is_ld) begin
            w = model_mem[idx] >> (8 * lane);
            if (nb == 1) begin
                e.data = sgn ? {{24{w[7]}}, w[7:0]} : {24'h0, w[7:0]};
            end else if (nb == 2) begin
                e.data = sgn ? {{16{w[15]}}, w[15:0]} : {16'h0, w[15:0]};
            end else begin
                e.data = w;
            end
            e.load_valid = 1'b1;
        end else begin
            // byte i of the store data lands in lane + i
            for (i = 0; i < nb; i++) begin
                model_mem[idx][(lane + i) * 8 +: 8] = d[i * 8 +: 8];
            end
        end
        return e;
    endfunction

    task automatic stop_on_error();
        $display("Finished with errors");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_word(string name, word_t expv, word_t actv);
        if (actv !== expv) begin
            $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expv, actv);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic expv, logic actv);
        if (actv !== expv) begin
            $display("ERR time=%0t signal=%s expected=%b actual=%b", $time, name, expv, actv);
            stop_on_error();
        end
    endtask

    // random base and offset split of a target address
    task automatic access(mem_op_t o, addr_t a, word_t d);
        int   off_i;
        exp_t e;
        off_i = $random(seed) % 64;
        @(posedge clk);
        op_valid   <= 1'b1;
        op         <= o;
        base       <= a - addr_t'(off_i);
        offset     <= off_i[11:0];
        store_data <= d;
        e     = model_op(o, a - addr_t'(off_i), off_i[11:0], d);
        e.due = cyc + 2;
        exp_q.push_back(e);
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            op_valid <= 1'b0;
        end
    endtask

    // compares in mid cycle, an idle cycle expects both pulses low
    initial begin
        exp_t e;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
            end else begin
                e = '0;
            end
            check_flag("load_valid", e.load_valid, load_valid);
            check_flag("ale", e.ale, ale);
            if (e.load_valid) begin
                check_word("load_data", e.data, load_data);
            end
            if (i_dut.u_asserts.fail_count != 0) begin
                $display("a bound assertion failed before time %0t", $time);
                stop_on_error();
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (2 * TOTAL_OPS + 50));
        $display("timeout: the run did not end within %0d clock periods", 2 * TOTAL_OPS + 50);
        stop_on_error();
    end

    initial begin
        addr_t   a;
        addr_t   last_a;
        logic    last_store;
        mem_op_t o;
        int      sel;
        int      nb;
        int      i;
        int      lane;
        word_t   v [2];
        seed       = 32'h9fbcbdd9;
        rst_n      = 1'b0;
        op_valid   = 1'b0;
        op         = '0;
        base       = '0;
        offset     = '0;
        store_data = '0;
        last_a     = WIN_BASE;
        last_store = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        idle(4);

        // fill the window, each word read back right after its store
        for (i = 0; i < WIN_WORDS; i++) begin
            a = WIN_BASE + addr_t'(4 * i);
            access(OP_ST_W, a, a ^ {a[15:0], a[31:16]} ^ 32'h3c96_a55a);
            access(OP_LD_W, a, '0);
        end
        idle(2);

        // byte and half merges
        access(OP_ST_W, 32'h210, 32'h0);
        for (lane = 0; lane < 4; lane++) begin
            access(OP_ST_B, 32'h210 + addr_t'(lane), $random(seed));
        end
        access(OP_LD_W, 32'h210, '0);
        access(OP_ST_H, 32'h212, 32'habcd_9876);
        access(OP_LD_W, 32'h210, '0);
        access(OP_ST_H, 32'h210, 32'h1234_c0de);
        access(OP_LD_W, 32'h210, '0);
        idle(2);

        // sign and zero extension
        v[0] = 32'hf08a_c3b7;
        v[1] = 32'h7f01_6e42;
        for (i = 0; i < 2; i++) begin
            a = 32'h220 + addr_t'(4 * i);
            access(OP_ST_W, a, v[i]);
            for (lane = 0; lane < 4; lane++) begin
                access(OP_LD_B, a + addr_t'(lane), '0);
                access(OP_LD_BU, a + addr_t'(lane), '0);
            end
            for (lane = 0; lane < 4; lane += 2) begin
                access(OP_LD_H, a + addr_t'(lane), '0);
                access(OP_LD_HU, a + addr_t'(lane), '0);
            end
            access(OP_LD_W, a, '0);
        end
        idle(2);

        // misaligned accesses fault and leave memory alone
        access(OP_LD_H, 32'h231, '0);
        access(OP_LD_HU, 32'h233, '0);
        access(OP_LD_W, 32'h232, '0);
        access(OP_LD_W, 32'h231, '0);
        access(OP_ST_H, 32'h231, 32'hffff_ffff);
        access(OP_ST_W, 32'h232, 32'hffff_ffff);
        access(OP_ST_W, 32'h233, 32'hffff_ffff);
        access(OP_LD_B, 32'h233, '0);
        access(OP_LD_W, 32'h230, '0);
        idle(2);

        for (i = 0; i < NUM_RANDOM; i++) begin
            sel = {$random(seed)} % 9;
            o   = (sel == 8) ? mem_op_t'(4'h7) : op_tbl[sel];
            if (last_store && ($random(seed) & 1)) begin
                a = {last_a[31:2], 2'($random(seed))};
            end else begin
                a = WIN_BASE + addr_t'({$random(seed)} % WIN_BYTES);
            end
            nb = op_bytes(o);
            // mostly aligned so that loads dominate over faults
            if (nb > 1 && ($random(seed) & 3) != 0) begin
                a = a & ~addr_t'(nb - 1);
            end
            access(o, a, $random(seed));
            last_store = o inside {OP_ST_B, OP_ST_H, OP_ST_W};
            last_a     = a;
        end
        idle(3);
        wait (exp_q.size() == 0);
        idle(2);

        if (i_dut.u_asserts.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "simulation ended with failures");
        end
    end

endmodule

// File: tb.f
hdl/mem_pkg.sv
hdl/mem_op_decode.sv
hdl/fakecache.sv
hdl/data_sram.sv
hdl/load_align.sv
hdl/mem_subsys.sv
dv/mem_subsys_asserts.sv
dv/mem_subsys_tb.sv
